// ==== hdl/udp_to_stream.sv ====
`timescale 1ns/1ps

module udp_to_stream (
     input  logic                       clk
    ,input  logic                       arst_n

    ,input  logic                       hdr_val
    ,input  udp_tx_pkg::noc_hdr_t       hdr
    ,output logic                       hdr_rdy

    ,input  logic                       in_beat_val
    ,input  udp_tx_pkg::stream_beat_t   in_beat
    ,output logic                       in_beat_rdy

    ,output logic                       meta_val
    ,output udp_tx_pkg::ip_meta_t       meta
    ,input  logic                       meta_rdy

    ,output logic                       out_beat_val
    ,output udp_tx_pkg::stream_beat_t   out_beat
    ,input  logic                       out_beat_rdy
);

    udp_tx_pkg::enc_state_e         state;
    udp_tx_pkg::len_t               udp_len;
    udp_tx_pkg::padbytes_t          last_pad;
    udp_tx_pkg::padbytes_t          tail_pad;
    logic [udp_tx_pkg::UDP_HDR_W-1:0] carry;
    logic                           meta_free;
    logic                           beat_free;
    logic                           hdr_fire;
    logic                           in_fire;
    logic                           tail_fire;
    logic                           short_last;

    assign udp_len = hdr.payload_len + udp_tx_pkg::len_t'(udp_tx_pkg::UDP_HDR_BYTES);

    assign meta_free   = !meta_val || meta_rdy;
    assign beat_free   = !out_beat_val || out_beat_rdy;
    assign hdr_rdy     = (state == udp_tx_pkg::enc_hdr) && meta_free;
    assign in_beat_rdy = (state == udp_tx_pkg::enc_data) && beat_free;
    assign hdr_fire    = hdr_val && hdr_rdy;
    assign in_fire     = in_beat_val && in_beat_rdy;
    assign tail_fire   = (state == udp_tx_pkg::enc_tail) && beat_free;

    // at most 8 valid bytes in the final input beat means no tail beat
    assign short_last = in_beat.last
                        && (in_beat.padbytes >= udp_tx_pkg::padbytes_t'(udp_tx_pkg::UDP_HDR_BYTES));

    // shifting by 8 bytes moves the pad by 8 mod 16, for the short beat and the tail alike
    assign last_pad = in_beat.padbytes + udp_tx_pkg::padbytes_t'(udp_tx_pkg::UDP_HDR_BYTES);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= udp_tx_pkg::enc_hdr;
            meta_val     <= 1'b0;
            out_beat_val <= 1'b0;
        end else begin
            if (meta_rdy) begin
                meta_val <= 1'b0;
            end
            if (out_beat_rdy) begin
                out_beat_val <= 1'b0;
            end
            case (state)
                udp_tx_pkg::enc_hdr: begin
                    if (hdr_fire) begin
                        meta_val <= 1'b1;
                        state    <= udp_tx_pkg::enc_data;
                    end
                end
                udp_tx_pkg::enc_data: begin
                    if (in_fire) begin
                        out_beat_val <= 1'b1;
                        if (short_last) begin
                            state <= udp_tx_pkg::enc_hdr;
                        end else if (in_beat.last) begin
                            state <= udp_tx_pkg::enc_tail;
                        end
                    end
                end
                udp_tx_pkg::enc_tail: begin
                    if (tail_fire) begin
                        out_beat_val <= 1'b1;
                        state        <= udp_tx_pkg::enc_hdr;
                    end
                end
                default: begin
                    state <= udp_tx_pkg::enc_hdr;
                end
            endcase
        end
    end

    // the UDP header starts out as the carry, so the first beat needs no special case
    always_ff @(posedge clk) begin
        if (hdr_fire) begin
            meta.src_ip    <= hdr.src_ip;
            meta.dst_ip    <= hdr.dst_ip;
            meta.udp_len   <= udp_len;
            meta.protocol  <= udp_tx_pkg::protocol_t'(udp_tx_pkg::UDP_PROTOCOL);
            meta.timestamp <= hdr.timestamp;
            carry          <= {hdr.src_port, hdr.dst_port, udp_len, 16'h0000};
        end
        if (in_fire) begin
            out_beat.data     <= {carry,
                                  in_beat.data[udp_tx_pkg::FLIT_W-1 -: udp_tx_pkg::UDP_HDR_W]};
            out_beat.last     <= short_last;
            out_beat.padbytes <= short_last ? last_pad : '0;
            carry             <= in_beat.data[udp_tx_pkg::UDP_HDR_W-1:0];
            tail_pad          <= last_pad;
        end
        if (tail_fire) begin
            out_beat.data     <= {carry, {udp_tx_pkg::UDP_HDR_W{1'b0}}};
            out_beat.last     <= 1'b1;
            out_beat.padbytes <= tail_pad;
        end
    end

endmodule

// ==== hdl/udp_tx_credit_fifo.sv ====
`timescale 1ns/1ps

module udp_tx_credit_fifo (
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic                   wr_val
    ,input  udp_tx_pkg::flit_t      wr_data
    ,output logic                   yummy

    ,output logic                   rd_val
    ,output udp_tx_pkg::flit_t      rd_data
    ,input  logic                   rd_rdy
);

    // one extra wrap bit on each pointer tells full from empty
    logic [udp_tx_pkg::CREDIT_PTR_W:0]  wr_ptr;
    logic [udp_tx_pkg::CREDIT_PTR_W:0]  rd_ptr;
    logic                               rd_fire;

    udp_tx_pkg::flit_t mem [udp_tx_pkg::CREDIT_DEPTH];

    assign rd_val  = (wr_ptr != rd_ptr);
    assign rd_fire = rd_val && rd_rdy;
    assign rd_data = mem[rd_ptr[udp_tx_pkg::CREDIT_PTR_W-1:0]];

    // the sender holds a credit for every write, so no full check here
    always_ff @(posedge clk) begin
        if (wr_val) begin
            mem[wr_ptr[udp_tx_pkg::CREDIT_PTR_W-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            yummy  <= 1'b0;
        end else begin
            if (wr_val) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // one credit goes back the cycle after each flit leaves
            yummy <= rd_fire;
        end
    end

endmodule

// ==== hdl/udp_tx_noc_in.sv ====
`timescale 1ns/1ps

module udp_tx_noc_in (
     input  logic                       clk
    ,input  logic                       arst_n

    ,input  logic                       flit_val
    ,input  udp_tx_pkg::flit_t          flit
    ,output logic                       flit_rdy

    ,output logic                       hdr_val
    ,output udp_tx_pkg::noc_hdr_t       hdr
    ,input  logic                       hdr_rdy

    ,output logic                       beat_val
    ,output udp_tx_pkg::stream_beat_t   beat
    ,input  logic                       beat_rdy
);

    udp_tx_pkg::in_state_e  state;
    udp_tx_pkg::noc_hdr_t   flit_hdr;
    udp_tx_pkg::len_t       flit_cnt;
    udp_tx_pkg::len_t       remaining;
    udp_tx_pkg::padbytes_t  last_pad;
    logic                   hdr_free;
    logic                   beat_free;
    logic                   flit_fire;
    logic                   final_flit;

    assign flit_hdr = udp_tx_pkg::noc_hdr_t'(flit);

    // payload flits per message, payload_len / 16 rounded up
    assign flit_cnt = (flit_hdr.payload_len + udp_tx_pkg::len_t'(udp_tx_pkg::FLIT_BYTES - 1))
                      >> udp_tx_pkg::FLIT_BYTES_W;

    // hdr keeps the current message until the next header is taken
    assign last_pad = udp_tx_pkg::padbytes_t'(udp_tx_pkg::FLIT_BYTES
                      - hdr.payload_len[udp_tx_pkg::FLIT_BYTES_W-1:0]);

    assign hdr_free   = !hdr_val || hdr_rdy;
    assign beat_free  = !beat_val || beat_rdy;
    assign flit_rdy   = (state == udp_tx_pkg::in_hdr) ? hdr_free : beat_free;
    assign flit_fire  = flit_val && flit_rdy;
    assign final_flit = (remaining == udp_tx_pkg::len_t'(1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= udp_tx_pkg::in_hdr;
            hdr_val   <= 1'b0;
            beat_val  <= 1'b0;
            remaining <= '0;
        end else begin
            if (hdr_rdy) begin
                hdr_val <= 1'b0;
            end
            if (beat_rdy) begin
                beat_val <= 1'b0;
            end
            if (flit_fire) begin
                if (state == udp_tx_pkg::in_hdr) begin
                    hdr_val   <= 1'b1;
                    remaining <= flit_cnt;
                    state     <= udp_tx_pkg::in_data;
                end else begin
                    beat_val  <= 1'b1;
                    remaining <= remaining - 1'b1;
                    if (final_flit) begin
                        state <= udp_tx_pkg::in_hdr;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flit_fire && (state == udp_tx_pkg::in_hdr)) begin
            hdr <= flit_hdr;
        end
        if (flit_fire && (state == udp_tx_pkg::in_data)) begin
            beat.data     <= flit;
            beat.last     <= final_flit;
            beat.padbytes <= final_flit ? last_pad : '0;
        end
    end

endmodule

// ==== hdl/udp_tx_noc_out.sv ====
`timescale 1ns/1ps

module udp_tx_noc_out (
     input  logic                       clk
    ,input  logic                       arst_n

    ,input  logic                       meta_val
    ,input  udp_tx_pkg::ip_meta_t       meta
    ,output logic                       meta_rdy

    ,input  logic                       beat_val
    ,input  udp_tx_pkg::stream_beat_t   beat
    ,output logic                       beat_rdy

    ,output logic                       out_val
    ,output udp_tx_pkg::flit_t          out_data
    ,input  logic                       out_rdy
);

    udp_tx_pkg::out_state_e state;
    udp_tx_pkg::out_hdr_t   hdr_flit;
    udp_tx_pkg::flit_t      keep_mask;
    logic                   out_free;
    logic                   meta_fire;
    logic                   beat_fire;

    assign out_free  = !out_val || out_rdy;
    assign meta_rdy  = (state == udp_tx_pkg::out_hdr) && out_free;
    assign beat_rdy  = (state == udp_tx_pkg::out_data) && out_free;
    assign meta_fire = meta_val && meta_rdy;
    assign beat_fire = beat_val && beat_rdy;

    always_comb begin
        hdr_flit.dst_ip    = meta.dst_ip;
        hdr_flit.src_ip    = meta.src_ip;
        hdr_flit.udp_len   = meta.udp_len;
        hdr_flit.protocol  = meta.protocol;
        hdr_flit.rsvd      = '0;
        hdr_flit.timestamp = meta.timestamp;
    end

    // pad bytes sit at the low end of the flit
    assign keep_mask = {udp_tx_pkg::FLIT_W{1'b1}} << {beat.padbytes, 3'b000};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= udp_tx_pkg::out_hdr;
            out_val <= 1'b0;
        end else begin
            if (out_rdy) begin
                out_val <= 1'b0;
            end
            if (meta_fire) begin
                out_val <= 1'b1;
                state   <= udp_tx_pkg::out_data;
            end
            if (beat_fire) begin
                out_val <= 1'b1;
                if (beat.last) begin
                    state <= udp_tx_pkg::out_hdr;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (meta_fire) begin
            out_data <= udp_tx_pkg::flit_t'(hdr_flit);
        end
        if (beat_fire) begin
            out_data <= beat.last ? (beat.data & keep_mask) : beat.data;
        end
    end

endmodule

// ==== hdl/udp_tx_pkg.sv ====
package udp_tx_pkg;

    localparam int FLIT_W        = 128;
    localparam int FLIT_BYTES    = 16;
    localparam int FLIT_BYTES_W  = $clog2(FLIT_BYTES);
    localparam int UDP_HDR_BYTES = 8;
    localparam int UDP_HDR_W     = UDP_HDR_BYTES * 8;
    localparam int UDP_PROTOCOL  = 17;
    localparam int CREDIT_DEPTH  = 4;
    localparam int CREDIT_PTR_W  = $clog2(CREDIT_DEPTH);

    typedef logic [FLIT_W-1:0]       flit_t;
    typedef logic [31:0]             ip_addr_t;
    typedef logic [15:0]             port_t;
    typedef logic [15:0]             len_t;
    typedef logic [15:0]             tstamp_t;
    typedef logic [7:0]              protocol_t;
    typedef logic [FLIT_BYTES_W-1:0] padbytes_t;

    // input header flit, most significant field first
    typedef struct packed {
        ip_addr_t   dst_ip;
        ip_addr_t   src_ip;
        port_t      src_port;
        port_t      dst_port;
        len_t       payload_len;
        tstamp_t    timestamp;
    } noc_hdr_t;

    typedef struct packed {
        ip_addr_t   src_ip;
        ip_addr_t   dst_ip;
        len_t       udp_len;
        protocol_t  protocol;
        tstamp_t    timestamp;
    } ip_meta_t;

    typedef struct packed {
        ip_addr_t   dst_ip;
        ip_addr_t   src_ip;
        len_t       udp_len;
        protocol_t  protocol;
        logic [23:0] rsvd;
        tstamp_t    timestamp;
    } out_hdr_t;

    // padbytes counts unused bytes at the low end of a last beat
    typedef struct packed {
        flit_t      data;
        logic       last;
        padbytes_t  padbytes;
    } stream_beat_t;

    typedef enum logic {
        in_hdr,
        in_data
    } in_state_e;

    typedef enum logic [1:0] {
        enc_hdr,
        enc_data,
        enc_tail
    } enc_state_e;

    typedef enum logic {
        out_hdr,
        out_data
    } out_state_e;

endpackage

// ==== hdl/udp_tx_tile.sv ====
`timescale 1ns/1ps

module udp_tx_tile (
     input  logic               clk
    ,input  logic               arst_n

    ,input  logic               in_val
    ,input  udp_tx_pkg::flit_t  in_data
    ,output logic               in_yummy

    ,output logic               out_val
    ,output udp_tx_pkg::flit_t  out_data
    ,input  logic               out_rdy
);

    logic                       fifo_in_val;
    udp_tx_pkg::flit_t          fifo_in_data;
    logic                       in_fifo_rdy;

    logic                       in_enc_hdr_val;
    udp_tx_pkg::noc_hdr_t       in_enc_hdr;
    logic                       enc_in_hdr_rdy;

    logic                       in_enc_beat_val;
    udp_tx_pkg::stream_beat_t   in_enc_beat;
    logic                       enc_in_beat_rdy;

    logic                       enc_out_meta_val;
    udp_tx_pkg::ip_meta_t       enc_out_meta;
    logic                       out_enc_meta_rdy;

    logic                       enc_out_beat_val;
    udp_tx_pkg::stream_beat_t   enc_out_beat;
    logic                       out_enc_beat_rdy;

    udp_tx_credit_fifo credit_fifo (
         .clk       (clk            )
        ,.arst_n    (arst_n         )
        ,.wr_val    (in_val         )
        ,.wr_data   (in_data        )
        ,.yummy     (in_yummy       )
        ,.rd_val    (fifo_in_val    )
        ,.rd_data   (fifo_in_data   )
        ,.rd_rdy    (in_fifo_rdy    )
    );

    udp_tx_noc_in tx_noc_in (
         .clk       (clk            )
        ,.arst_n    (arst_n         )
        ,.flit_val  (fifo_in_val    )
        ,.flit      (fifo_in_data   )
        ,.flit_rdy  (in_fifo_rdy    )
        ,.hdr_val   (in_enc_hdr_val )
        ,.hdr       (in_enc_hdr     )
        ,.hdr_rdy   (enc_in_hdr_rdy )
        ,.beat_val  (in_enc_beat_val)
        ,.beat      (in_enc_beat    )
        ,.beat_rdy  (enc_in_beat_rdy)
    );

    udp_to_stream to_stream (
         .clk           (clk                )
        ,.arst_n        (arst_n             )
        ,.hdr_val       (in_enc_hdr_val     )
        ,.hdr           (in_enc_hdr         )
        ,.hdr_rdy       (enc_in_hdr_rdy     )
        ,.in_beat_val   (in_enc_beat_val    )
        ,.in_beat       (in_enc_beat        )
        ,.in_beat_rdy   (enc_in_beat_rdy    )
        ,.meta_val      (enc_out_meta_val   )
        ,.meta          (enc_out_meta       )
        ,.meta_rdy      (out_enc_meta_rdy   )
        ,.out_beat_val  (enc_out_beat_val   )
        ,.out_beat      (enc_out_beat       )
        ,.out_beat_rdy  (out_enc_beat_rdy   )
    );

    udp_tx_noc_out tx_noc_out (
         .clk       (clk                )
        ,.arst_n    (arst_n             )
        ,.meta_val  (enc_out_meta_val   )
        ,.meta      (enc_out_meta       )
        ,.meta_rdy  (out_enc_meta_rdy   )
        ,.beat_val  (enc_out_beat_val   )
        ,.beat      (enc_out_beat       )
        ,.beat_rdy  (out_enc_beat_rdy   )
        ,.out_val   (out_val            )
        ,.out_data  (out_data           )
        ,.out_rdy   (out_rdy            )
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module udp_tx_tile_tb \
    -f verilog.f --Mdir obj_dir -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation ended without passing"; exit 1; }
echo "simulation passed"

// ==== verif/udp_tx_tile_props.sv ====
`timescale 1ns/1ps

module udp_tx_tile_props (
     input  logic               clk
    ,input  logic               arst_n
    ,input  logic               in_val
    ,input  logic               in_yummy
    ,input  logic               out_val
    ,input  udp_tx_pkg::flit_t  out_data
    ,input  logic               out_rdy
);

    // flits written into the tile whose credit has not come back yet
    logic [7:0] unreturned;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            unreturned <= '0;
        end else begin
            unreturned <= unreturned + 8'(in_val) - 8'(in_yummy);
        end
    end

    // a stalled output flit holds its value until it is taken
    out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_val && !out_rdy |=> out_val && $stable(out_data))
        else $error("out_data changed or out_val dropped while out_rdy was low");

    // a credit only comes back for a flit that went into the buffer
    yummy_for_stored_flit: assert property (@(posedge clk) disable iff (!arst_n)
        in_yummy |-> unreturned != 8'd0)
        else $error("in_yummy pulsed while the input buffer held no flit");

    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !out_val && !in_yummy)
        else $error("out_val or in_yummy high while the tile is in reset");

endmodule

bind udp_tx_tile udp_tx_tile_props udp_tx_tile_props_inst (
     .clk           (clk        )
    ,.arst_n        (arst_n     )
    ,.in_val        (in_val     )
    ,.in_yummy      (in_yummy   )
    ,.out_val       (out_val    )
    ,.out_data      (out_data   )
    ,.out_rdy       (out_rdy    )
);

// ==== verif/udp_tx_tile_tb.sv ====
`timescale 1ns/1ps

module udp_tx_tile_tb;

    logic                   clk;
    logic                   arst_n;
    logic                   in_val;
    udp_tx_pkg::flit_t      in_data;
    logic                   in_yummy;
    logic                   out_val;
    udp_tx_pkg::flit_t      out_data;
    logic                   out_rdy;

    // input flits waiting for a credit, and expected output flits in order
    udp_tx_pkg::flit_t      send_q[$];
    udp_tx_pkg::flit_t      exp_q[$];
    logic                   exp_hdr_q[$];
    string                  exp_name_q[$];

    logic [7:0]             pay [0:1023];
    int                     credits;
    int                     flits_sent;
    int                     yummies;
    logic                   stall_en;
    int unsigned            gen_state;
    int unsigned            rdy_state;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    udp_tx_tile udp_tx_tile_inst (
         .clk       (clk     )
        ,.arst_n    (arst_n  )
        ,.in_val    (in_val  )
        ,.in_data   (in_data )
        ,.in_yummy  (in_yummy)
        ,.out_val   (out_val )
        ,.out_data  (out_data)
        ,.out_rdy   (out_rdy )
    );

    function automatic int unsigned lcg(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [15:0] rand16();
        gen_state = lcg(gen_state);
        return gen_state[31:16];
    endfunction

    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        hi = rand16();
        return {hi, rand16()};
    endfunction

    // flit idx of the output message, idx 0 being the header flit
    function automatic udp_tx_pkg::flit_t expected_flit(input udp_tx_pkg::noc_hdr_t h,
                                                        input int idx);
        udp_tx_pkg::out_hdr_t   oh;
        udp_tx_pkg::flit_t      f;
        udp_tx_pkg::len_t       ulen;
        logic [63:0]            uh;
        logic [7:0]             b;
        int                     k;
        ulen = h.payload_len + 16'd8;
        if (idx == 0) begin
            oh.dst_ip    = h.dst_ip;
            oh.src_ip    = h.src_ip;
            oh.udp_len   = ulen;
            oh.protocol  = 8'd17;
            oh.rsvd      = '0;
            oh.timestamp = h.timestamp;
            return udp_tx_pkg::flit_t'(oh);
        end
        uh = {h.src_port, h.dst_port, ulen, 16'h0000};
        f = '0;
        for (int j = 0; j < 16; j++) begin
            k = (idx - 1) * 16 + j;
            if (k < 8) begin
                b = uh[63 - 8 * k -: 8];
            end else if (k - 8 < int'(h.payload_len)) begin
                b = pay[k - 8];
            end else begin
                b = 8'h00;
            end
            f[127 - 8 * j -: 8] = b;
        end
        return f;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_hdr(input string name, input udp_tx_pkg::out_hdr_t exp,
                             input udp_tx_pkg::out_hdr_t act);
        if (act !== exp) begin
            stop_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input udp_tx_pkg::flit_t exp,
                              input udp_tx_pkg::flit_t act);
        if (act !== exp) begin
            stop_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic flag_is(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic count_is(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_run($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    // trailing input bytes past the payload are random and must not reach the output
    task automatic queue_message(input string name, input int len);
        udp_tx_pkg::noc_hdr_t   h;
        udp_tx_pkg::flit_t      f;
        logic [15:0]            r;
        int                     nout;
        h.dst_ip      = rand32();
        h.src_ip      = rand32();
        h.src_port    = rand16();
        h.dst_port    = rand16();
        h.payload_len = udp_tx_pkg::len_t'(len);
        h.timestamp   = rand16();
        for (int i = 0; i < len; i++) begin
            r = rand16();
            pay[i] = r[7:0];
        end
        send_q.push_back(udp_tx_pkg::flit_t'(h));
        for (int fi = 0; fi < (len + 15) / 16; fi++) begin
            for (int j = 0; j < 16; j++) begin
                r = rand16();
                f[127 - 8 * j -: 8] = (fi * 16 + j < len) ? pay[fi * 16 + j] : r[7:0];
            end
            send_q.push_back(f);
        end
        nout = (len + 8 + 15) / 16;
        for (int i = 0; i <= nout; i++) begin
            exp_q.push_back(expected_flit(h, i));
            exp_hdr_q.push_back(i == 0);
            exp_name_q.push_back($sformatf("%s flit %0d", name, i));
        end
    endtask

    task automatic wait_idle(input string name);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || send_q.size() != 0) begin
            if (cycles >= 20000) begin
                stop_run($sformatf("%s: the tile did not finish its messages in %0d cycles",
                                   name, cycles));
            end else begin
                @(posedge clk);
                #5;
                cycles++;
            end
        end
    endtask

    task automatic run_single(input string name, input int len);
        queue_message(name, len);
        wait_idle(name);
    endtask

    // the driver spends one credit per flit and randomly stalls the output
    always @(posedge clk) begin
        #1;
        rdy_state = lcg(rdy_state);
        out_rdy = stall_en ? (rdy_state[31:30] != 2'b00) : 1'b1;
        in_val = 1'b0;
        if (send_q.size() > 0 && credits > 0) begin
            in_val  = 1'b1;
            in_data = send_q.pop_front();
            credits--;
            flits_sent++;
        end
    end

    always @(negedge clk) begin : monitor
        udp_tx_pkg::flit_t  exp_flit;
        logic               exp_is_hdr;
        string              exp_name;
        if (in_yummy) begin
            yummies++;
            credits++;
            if (credits > udp_tx_pkg::CREDIT_DEPTH) begin
                stop_run("in_yummy returned more credits than the driver had spent");
            end
        end
        if (out_val && out_rdy) begin
            if (exp_q.size() == 0) begin
                stop_run("an output flit arrived while no message was outstanding");
            end else begin
                exp_flit   = exp_q.pop_front();
                exp_is_hdr = exp_hdr_q.pop_front();
                exp_name   = exp_name_q.pop_front();
                if (exp_is_hdr) begin
                    check_hdr(exp_name, udp_tx_pkg::out_hdr_t'(exp_flit),
                              udp_tx_pkg::out_hdr_t'(out_data));
                end else begin
                    check_data(exp_name, exp_flit, out_data);
                end
            end
        end
    end

    initial begin
        logic [15:0] r;
        arst_n         = 1'b0;
        in_val         = 1'b0;
        in_data        = '0;
        out_rdy        = 1'b1;
        stall_en       = 1'b0;
        credits        = udp_tx_pkg::CREDIT_DEPTH;
        flits_sent     = 0;
        yummies        = 0;
        gen_state      = 25;
        rdy_state      = 25;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            flag_is("reset out_val", 1'b0, out_val);
            flag_is("reset in_yummy", 1'b0, in_yummy);
        end
        arst_n = 1'b1;
        @(posedge clk);
        #5;
        flag_is("after reset out_val", 1'b0, out_val);
        flag_is("after reset in_yummy", 1'b0, in_yummy);

        run_single("single 5 bytes", 5);
        run_single("boundary 8 bytes", 8);
        run_single("boundary 16 bytes", 16);
        run_single("boundary 24 bytes", 24);

        // all random messages go in back to back, so several are in flight
        stall_en = 1'b1;
        for (int m = 0; m < 30; m++) begin
            r = rand16();
            queue_message($sformatf("random %0d", m), int'(r % 16'd64) + 1);
        end
        wait_idle("random messages");
        stall_en = 1'b0;

        repeat (20) @(posedge clk);
        #5;
        count_is("total yummy pulses", flits_sent, yummies);
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/udp_tx_pkg.sv
hdl/udp_tx_credit_fifo.sv
hdl/udp_tx_noc_in.sv
hdl/udp_to_stream.sv
hdl/udp_tx_noc_out.sv
hdl/udp_tx_tile.sv
verif/udp_tx_tile_props.sv
verif/udp_tx_tile_tb.sv
